// File: logic/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
        input  alu_op_t op,
        input  word_t   a,
        input  word_t   b,
        output word_t   result
);

logic [4:0] shamt;
logic       lt;
logic       ltu;

assign shamt = b[4:0];                  // upper bits of b never shift
assign lt    = ($signed(a) < $signed(b));
assign ltu   = (a < b);

always_comb
begin : compute
        case (op)
                ALU_ADD:
                        result = a + b;
                ALU_SUB:
                        result = a - b;
                ALU_AND:
                        result = a & b;
                ALU_OR:
                        result = a | b;
                ALU_XOR:
                        result = a ^ b;
                ALU_SLT:
                        result = {31'b0, lt};
                ALU_SLTU:
                        result = {31'b0, ltu};
                ALU_SLL:
                        result = a << shamt;
                ALU_SRL:
                        result = a >> shamt;
                ALU_SRA:
                        result = word_t'($signed(a) >>> shamt);
                default:
                        result = a + b;
        endcase
end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
        input  opcode_t            opcode,
        input  instruction_op_type optype,
        input  funct3_t            funct3,
        input  word_t              rs1_data,
        input  word_t              rs2_data,

        output logic               ctrl_mem_write,
        output logic               ctrl_mem_read,
        output logic               ctrl_mem_to_reg,
        output logic               ctrl_reg_wr_en,
        output logic               ctrl_alu_src,
        output logic               ctrl_is_branch,
        output logic               ctrl_is_jump,
        output logic               ctrl_branch_taken,
        output logic               ctrl_jump_taken
);

logic zero_flag;
logic lt_flag;
logic ltu_flag;
logic gte_flag;
logic gteu_flag;
logic cond;

assign zero_flag = (rs1_data == rs2_data);
assign lt_flag   = ($signed(rs1_data) < $signed(rs2_data));
assign ltu_flag  = (rs1_data < rs2_data);
assign gte_flag  = !lt_flag;
assign gteu_flag = !ltu_flag;

// branch condition by funct3, the two unused codes never branch
always_comb
begin : resolve_branch
        case (funct3)
                BEQ:     cond = zero_flag;
                BNE:     cond = !zero_flag;
                BLT:     cond = lt_flag;
                BGE:     cond = gte_flag;
                BLTU:    cond = ltu_flag;
                BGEU:    cond = gteu_flag;
                default: cond = 1'b0;
        endcase
end

always_comb
begin : generate_signals
        ctrl_mem_write    = 1'b0;
        ctrl_mem_read     = 1'b0;
        ctrl_mem_to_reg   = 1'b0;
        ctrl_reg_wr_en    = 1'b0;
        ctrl_alu_src      = 1'b0;
        ctrl_is_branch    = 1'b0;
        ctrl_is_jump      = 1'b0;
        ctrl_branch_taken = 1'b0;
        ctrl_jump_taken   = 1'b0;

        case (optype)
                R_TYPE:
                        ctrl_reg_wr_en = 1'b1;
                I_TYPE:
                begin
                        ctrl_reg_wr_en = 1'b1;
                        ctrl_alu_src   = 1'b1;
                        if (opcode == LOAD)
                        begin
                                ctrl_mem_read   = 1'b1;
                                ctrl_mem_to_reg = 1'b1;
                        end
                end
                S_TYPE:
                begin
                        ctrl_alu_src   = 1'b1;  // rs1 + offset is the address
                        ctrl_mem_write = 1'b1;
                end
                B_TYPE:
                begin
                        ctrl_is_branch    = 1'b1;
                        ctrl_branch_taken = cond;
                end
                U_TYPE:
                        ctrl_reg_wr_en = (opcode == U_LUI); // immediate goes straight to rd
                J_TYPE:
                begin
                        ctrl_reg_wr_en  = 1'b1;         // link register
                        ctrl_is_jump    = 1'b1;
                        ctrl_jump_taken = 1'b1;
                end
                default:
                        ctrl_reg_wr_en = 1'b0;
        endcase
end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ps

module data_mem import rv_pkg::*; #(
        parameter int DMEM_WORDS = 256
) (
        input  logic  clk,
        input  logic  arst_n,

        input  word_t addr,
        input  logic  wen,
        input  word_t wdata,
        output word_t rdata
);

localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

word_t            mem [DMEM_WORDS];
logic [IDX_W-1:0] idx;

// byte offset is dropped, the word address wraps at the depth
assign idx = IDX_W'(addr[31:2] % DMEM_WORDS);

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                for (int i = 0; i < DMEM_WORDS; i++)
                        mem[i] <= '0;
        end
        else if (wen)
        begin
                mem[idx] <= wdata;
        end
end

assign rdata = mem[idx];

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import rv_pkg::*; (
        input  word_t    instr,
        output decoded_t dec
);

logic [6:0] funct7;

assign funct7 = instr[31:25];

always_comb
begin : decode_fields
        dec        = '0;
        dec.opcode = instr[6:0];
        dec.funct3 = instr[14:12];
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.optype = BAD_TYPE;          // unknown opcodes fall through as a no-op
        dec.alu_op = ALU_ADD;

        case (instr[6:0])
                OP:
                        dec.optype = R_TYPE;
                OP_IMM, LOAD:
                begin
                        dec.optype = I_TYPE;
                        dec.imm    = {{20{instr[31]}}, instr[31:20]};
                end
                STORE:
                begin
                        dec.optype = S_TYPE;
                        dec.imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                BRANCH:
                begin
                        dec.optype = B_TYPE;
                        dec.imm    = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
                end
                U_LUI:
                begin
                        dec.optype = U_TYPE;
                        dec.imm    = {instr[31:12], 12'b0};
                end
                JAL:
                begin
                        dec.optype = J_TYPE;
                        dec.imm    = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
                end
                default:
                        dec.optype = BAD_TYPE;
        endcase

        // loads and stores keep ADD for the address
        if (instr[6:0] == OP || instr[6:0] == OP_IMM)
        begin
                case (instr[14:12])
                        3'b000: dec.alu_op = (instr[6:0] == OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                        3'b001: dec.alu_op = ALU_SLL;
                        3'b010: dec.alu_op = ALU_SLT;
                        3'b011: dec.alu_op = ALU_SLTU;
                        3'b100: dec.alu_op = ALU_XOR;
                        3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL; // srai keeps bit 30 too
                        3'b110: dec.alu_op = ALU_OR;
                        default: dec.alu_op = ALU_AND;
                endcase
        end
end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
        input  logic      clk,
        input  logic      arst_n,

        input  reg_addr_t rs1_addr,
        input  reg_addr_t rs2_addr,
        output word_t     rs1_data,
        output word_t     rs2_data,

        input  logic      wen,
        input  reg_addr_t waddr,
        input  word_t     wdata
);

word_t regs [32];

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                for (int i = 0; i < 32; i++)
                        regs[i] <= '0;
        end
        else if (wen && waddr != '0)    // x0 is never written
        begin
                regs[waddr] <= wdata;
        end
end

// read ports see the old value in the cycle of a write
assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
        parameter int    DMEM_WORDS = 256,
        parameter word_t RESET_PC   = '0
) (
        input  logic    clk,
        input  logic    arst_n,

        output logic    imem_req_valid,
        output word_t   imem_req_addr,
        input  logic    imem_req_ready,

        input  logic    imem_rsp_valid,
        input  word_t   imem_rsp_data,
        output logic    imem_rsp_ready,

        output logic    retire_valid,
        output retire_t retire,
        input  logic    retire_ready
);

core_state_t state;
word_t       pc;
word_t       instr_q;
decoded_t    dec;

logic req_fire;
logic rsp_fire;
logic retire_fire;

logic ctrl_mem_write;
logic ctrl_mem_read;
logic ctrl_mem_to_reg;
logic ctrl_reg_wr_en;
logic ctrl_alu_src;
logic ctrl_is_branch;
logic ctrl_is_jump;
logic ctrl_branch_taken;
logic ctrl_jump_taken;

word_t rs1_data;
word_t rs2_data;
word_t alu_b;
word_t alu_result;
word_t mem_rdata;
word_t wb_data;
word_t pc_plus4;
word_t pc_target;
word_t next_pc;

// ##############################
// handshakes and state
// ##############################

assign imem_req_valid = (state == FETCH);
assign imem_req_addr  = pc;
assign imem_rsp_ready = (state == WAIT_INSTR);
assign retire_valid   = (state == RETIRE);

assign req_fire    = imem_req_valid && imem_req_ready;
assign rsp_fire    = imem_rsp_valid && imem_rsp_ready;
assign retire_fire = retire_valid && retire_ready;

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                state <= FETCH;
                pc    <= RESET_PC;
        end
        else
        begin
                case (state)
                        FETCH:
                                if (req_fire)
                                        state <= WAIT_INSTR;
                        WAIT_INSTR:
                                if (rsp_fire)
                                        state <= RETIRE;
                        RETIRE:
                                if (retire_fire)
                                begin
                                        state <= FETCH;
                                        pc    <= next_pc;   // the only pc update
                                end
                        default:
                                state <= FETCH;
                endcase
        end
end

always_ff @(posedge clk)
begin
        if (rsp_fire)
                instr_q <= imem_rsp_data;
end

// ##############################
// datapath
// ##############################

instr_decoder instr_decoder_i (
        .instr (instr_q),
        .dec   (dec)
);

control_unit control_unit_i (
        .opcode            (dec.opcode),
        .optype            (dec.optype),
        .funct3            (dec.funct3),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .ctrl_mem_write    (ctrl_mem_write),
        .ctrl_mem_read     (ctrl_mem_read),
        .ctrl_mem_to_reg   (ctrl_mem_to_reg),
        .ctrl_reg_wr_en    (ctrl_reg_wr_en),
        .ctrl_alu_src      (ctrl_alu_src),
        .ctrl_is_branch    (ctrl_is_branch),
        .ctrl_is_jump      (ctrl_is_jump),
        .ctrl_branch_taken (ctrl_branch_taken),
        .ctrl_jump_taken   (ctrl_jump_taken)
);

reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (retire_fire && ctrl_reg_wr_en),
        .waddr    (dec.rd),
        .wdata    (wb_data)
);

assign alu_b = ctrl_alu_src ? dec.imm : rs2_data;

alu alu_i (
        .op     (dec.alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
);

data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
) data_mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (alu_result),
        .wen    (retire_fire && ctrl_mem_write), // stores land with the retirement
        .wdata  (rs2_data),
        .rdata  (mem_rdata)
);

assign pc_plus4  = pc + 32'd4;
assign pc_target = pc + dec.imm;
assign next_pc   = ((ctrl_is_branch && ctrl_branch_taken) || ctrl_jump_taken) ?
                   pc_target : pc_plus4;

always_comb
begin : write_back
        if (ctrl_mem_read && ctrl_mem_to_reg)
                wb_data = mem_rdata;
        else if (ctrl_is_jump)
                wb_data = pc_plus4;     // link address
        else if (dec.opcode == U_LUI)
                wb_data = dec.imm;
        else
                wb_data = alu_result;
end

// rd and its data read as zero when nothing is written
assign retire.pc      = pc;
assign retire.next_pc = next_pc;
assign retire.rd      = ctrl_reg_wr_en ? dec.rd : '0;
assign retire.rd_wen  = ctrl_reg_wr_en;
assign retire.rd_data = ctrl_reg_wr_en ? wb_data : '0;

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

// ##############################
// widths
// ##############################

typedef logic [31:0] word_t;            // data word, address or instruction
typedef logic [4:0]  reg_addr_t;
typedef logic [6:0]  opcode_t;
typedef logic [2:0]  funct3_t;

typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE,
        BAD_TYPE
} instruction_op_type;

// ##############################
// encodings
// ##############################

localparam opcode_t OP     = 7'b0110011;
localparam opcode_t OP_IMM = 7'b0010011;
localparam opcode_t LOAD   = 7'b0000011;
localparam opcode_t STORE  = 7'b0100011;
localparam opcode_t BRANCH = 7'b1100011;
localparam opcode_t U_LUI  = 7'b0110111;
localparam opcode_t JAL    = 7'b1101111;

localparam funct3_t BEQ  = 3'b000;
localparam funct3_t BNE  = 3'b001;
localparam funct3_t BLT  = 3'b100;
localparam funct3_t BGE  = 3'b101;
localparam funct3_t BLTU = 3'b110;
localparam funct3_t BGEU = 3'b111;

typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
} alu_op_t;

typedef struct packed {
        opcode_t            opcode;
        instruction_op_type optype;
        funct3_t            funct3;
        reg_addr_t          rd;
        reg_addr_t          rs1;
        reg_addr_t          rs2;
        word_t              imm;        // already sign extended
        alu_op_t            alu_op;
} decoded_t;

typedef struct packed {
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd;
        logic      rd_wen;
        word_t     rd_data;
} retire_t;

typedef enum logic [1:0] {
        FETCH,
        WAIT_INSTR,
        RETIRE
} core_state_t;

endpackage

// File: sources.f
logic/rv_pkg.sv
logic/instr_decoder.sv
logic/control_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/data_mem.sv
logic/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: verif/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; (
        input logic    clk,
        input logic    arst_n,
        input logic    imem_req_valid,
        input word_t   imem_req_addr,
        input logic    imem_req_ready,
        input logic    imem_rsp_valid,
        input word_t   imem_rsp_data,
        input logic    imem_rsp_ready,
        input logic    retire_valid,
        input retire_t retire,
        input logic    retire_ready
);

int prop_errors = 0;

// ##############################
// stream stability
// ##############################

req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr))
else
begin
        $error("fetch request dropped or changed before ready");
        prop_errors++;
end

rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        imem_rsp_valid && !imem_rsp_ready |=> imem_rsp_valid && $stable(imem_rsp_data))
else
begin
        $error("fetch response dropped or changed before ready");
        prop_errors++;
end

retire_hold: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
else
begin
        $error("retirement dropped or changed before ready");
        prop_errors++;
end

// first edge after release sees an idle retire stream
idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !retire_valid)
else
begin
        $error("retire_valid high right after reset");
        prop_errors++;
end

req_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req_valid |-> imem_req_addr[1:0] == 2'b00)
else
begin
        $error("fetch address not word aligned");
        prop_errors++;
end

endmodule

bind rv_core rv_core_props rv_core_props_i (.*);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

localparam int TIMEOUT     = 50;       // cycles allowed per wait
localparam int MAX_RETIRE  = 200;
localparam int MODEL_WORDS = 256;

logic    clk;
logic    arst_n;
logic    imem_req_valid;
word_t   imem_req_addr;
logic    imem_req_ready;
logic    imem_rsp_valid;
word_t   imem_rsp_data;
logic    imem_rsp_ready;
logic    retire_valid;
retire_t retire;
logic    retire_ready;

integer seed = 82;
word_t  prog [128];
int     prog_len;
word_t  m_regs [32];
word_t  m_mem [MODEL_WORDS];
word_t  m_pc;

rv_core #(
        .DMEM_WORDS (MODEL_WORDS),
        .RESET_PC   ('0)
) rv_core_i (
        .*
);

always #50 clk = ~clk;

// ##############################
// instruction encoding
// ##############################

function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                input reg_addr_t rs1, input funct3_t f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                input funct3_t f3, input reg_addr_t rd, input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

task automatic put(input word_t w);
        prog[prog_len] = w;
        prog_len++;
endtask

// a taken branch skips the counter bump behind it
task automatic add_branch(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2);
        put(enc_b(13'd8, rs2, rs1, f3));
        put(enc_i(12'd1, 30, 3'b000, 30, OP_IMM));
endtask

task automatic build_program();
        prog_len = 0;
        put({20'h80000, 5'd1, U_LUI});
        put(enc_i(12'hffb, 0, 3'b000, 2, OP_IMM));       // x2 = -5
        put(enc_i(12'd7, 0, 3'b000, 3, OP_IMM));
        put(enc_i(12'd9, 0, 3'b000, 0, OP_IMM));         // x0 stays zero
        put(enc_r(7'h00, 0, 0, 3'b000, 4));
        put(enc_i(12'h0f0, 2, 3'b100, 5, OP_IMM));
        put(enc_i(12'h07f, 2, 3'b111, 6, OP_IMM));
        put(enc_i(12'h100, 3, 3'b110, 7, OP_IMM));
        put(enc_i(12'd3, 2, 3'b010, 8, OP_IMM));
        put(enc_i(12'd3, 2, 3'b011, 9, OP_IMM));
        put(enc_i(12'd4, 3, 3'b001, 10, OP_IMM));
        put(enc_i(12'd3, 1, 3'b101, 11, OP_IMM));
        put(enc_i(12'h403, 1, 3'b101, 12, OP_IMM));       // srai
        put(enc_i(12'h400, 3, 3'b000, 29, OP_IMM));       // bit 30 set but still an add
        put(enc_r(7'h20, 2, 3, 3'b000, 13));
        put(enc_r(7'h20, 3, 2, 3'b101, 14));
        put(enc_r(7'h00, 3, 2, 3'b101, 15));
        put(enc_r(7'h00, 3, 2, 3'b001, 16));
        put(enc_r(7'h00, 3, 2, 3'b010, 17));
        put(enc_r(7'h00, 3, 2, 3'b011, 18));
        put(enc_r(7'h00, 3, 2, 3'b111, 19));
        put(enc_r(7'h00, 3, 2, 3'b110, 20));
        put(enc_r(7'h00, 3, 2, 3'b100, 21));
        put(enc_r(7'h20, 3, 2, 3'b000, 22));
        add_branch(BEQ, 3, 3);
        add_branch(BEQ, 2, 3);
        add_branch(BNE, 2, 3);
        add_branch(BNE, 3, 3);
        add_branch(BLT, 2, 3);
        add_branch(BLT, 3, 2);
        add_branch(BGE, 3, 2);
        add_branch(BGE, 2, 3);
        add_branch(BLTU, 3, 2);
        add_branch(BLTU, 2, 3);
        add_branch(BGEU, 2, 3);
        add_branch(BGEU, 3, 2);
        put(enc_i(12'd2, 0, 3'b000, 31, OP_IMM));
        put(enc_i(12'hfff, 31, 3'b000, 31, OP_IMM));     // loop body runs twice
        put(enc_b(13'h1ffc, 0, 31, BNE));
        put(enc_j(21'd8, 1));
        put(enc_i(12'd1, 30, 3'b000, 30, OP_IMM));
        put(32'h0000000f);                                // fence is not supported
        put(enc_i(12'd64, 0, 3'b000, 23, OP_IMM));
        put(enc_s(12'd0, 2, 23));
        put(enc_s(12'd4, 3, 23));
        put(enc_i(12'd0, 23, 3'b010, 24, LOAD));
        put(enc_i(12'd4, 23, 3'b010, 25, LOAD));
        put(enc_s(12'hff8, 1, 23));
        put(enc_i(12'hff8, 23, 3'b010, 26, LOAD));
        put(enc_i(12'd12, 23, 3'b010, 27, LOAD));
        put(enc_r(7'h00, 25, 24, 3'b000, 28));
endtask

// ##############################
// reference model
// ##############################

function automatic word_t alu_model(input funct3_t f3, input logic alt,
                                    input word_t a, input word_t b);
        case (f3)
                3'b000:  return alt ? a - b : a + b;
                3'b001:  return a << b[4:0];
                3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  return (a < b) ? 32'd1 : 32'd0;
                3'b100:  return a ^ b;
                3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  return a | b;
                default: return a & b;
        endcase
endfunction

function automatic int mem_index(input word_t addr);
        return int'(addr[31:2] % MODEL_WORDS);
endfunction

task automatic step_model(input word_t ins, output retire_t expected);
        word_t a;
        word_t b;
        word_t val;
        word_t npc;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  wen;
        logic  take;

        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        val   = '0;
        wen   = 1'b0;
        take  = 1'b0;
        npc   = m_pc + 32'd4;
        case (ins[6:0])
                OP:
                begin
                        val = alu_model(ins[14:12], ins[30], a, b);
                        wen = 1'b1;
                end
                OP_IMM:
                begin
                        val = alu_model(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
                        wen = 1'b1;
                end
                LOAD:
                begin
                        val = m_mem[mem_index(a + imm_i)];
                        wen = 1'b1;
                end
                STORE:
                        m_mem[mem_index(a + imm_s)] = b;
                BRANCH:
                begin
                        case (ins[14:12])
                                BEQ:     take = (a == b);
                                BNE:     take = (a != b);
                                BLT:     take = ($signed(a) < $signed(b));
                                BGE:     take = ($signed(a) >= $signed(b));
                                BLTU:    take = (a < b);
                                BGEU:    take = (a >= b);
                                default: take = 1'b0;
                        endcase
                        if (take)
                                npc = m_pc + imm_b;
                end
                U_LUI:
                begin
                        val = {ins[31:12], 12'b0};
                        wen = 1'b1;
                end
                JAL:
                begin
                        val = m_pc + 32'd4;
                        npc = m_pc + imm_j;
                        wen = 1'b1;
                end
                default:
                        wen = 1'b0;             // anything else retires as a no-op
        endcase
        expected.pc      = m_pc;
        expected.next_pc = npc;
        expected.rd      = wen ? ins[11:7] : '0;
        expected.rd_wen  = wen;
        expected.rd_data = wen ? val : '0;
        if (wen && ins[11:7] != '0)
                m_regs[ins[11:7]] = val;
        m_pc = npc;
endtask

// ##############################
// checks and bus driving
// ##############################

task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected)
        else
                stop_on_error($sformatf("[FAIL] %0d ns: %s is %h, expected %h",
                                        $time, name, got, expected));
endtask

// a failed bound property ends the run at once
always @(negedge clk)
begin
        if (rv_core_i.rv_core_props_i.prop_errors != 0)
                stop_on_error("a handshake property failed during the run");
end

task automatic run_instruction();
        word_t   addr;
        word_t   ins;
        retire_t expected;
        int      n;
        logic    early_rsp;

        repeat ($random(seed) & 3) @(negedge clk);
        n = 0;
        while (!imem_req_valid)
        begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT)
                        stop_on_error("timeout while waiting for a fetch request");
        end
        check_value("retire_valid before fetch", {31'b0, retire_valid}, '0);
        check_value("fetch address", imem_req_addr, m_pc);
        addr           = imem_req_addr;
        ins            = prog[addr[31:2]];
        early_rsp      = $random(seed) & 1;
        imem_req_ready = 1'b1;
        if (early_rsp)
        begin
                imem_rsp_data  = ins;           // response offered before the core waits for it
                imem_rsp_valid = 1'b1;
        end
        @(negedge clk);
        imem_req_ready = 1'b0;

        if (!early_rsp)
                repeat ($random(seed) & 3) @(negedge clk);
        imem_rsp_data  = ins;
        imem_rsp_valid = 1'b1;
        n = 0;
        while (!imem_rsp_ready)
        begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT)
                        stop_on_error("timeout while waiting for the core to take an instruction");
        end
        check_value("retire_valid before response", {31'b0, retire_valid}, '0);
        @(negedge clk);
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = $random(seed);         // junk between responses

        repeat ($random(seed) & 3) @(negedge clk);
        n = 0;
        while (!retire_valid)
        begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT)
                        stop_on_error("timeout while waiting for a retirement");
        end
        step_model(ins, expected);
        check_value("retire pc", retire.pc, expected.pc);
        check_value("retire next_pc", retire.next_pc, expected.next_pc);
        check_value("retire rd", {27'b0, retire.rd}, {27'b0, expected.rd});
        check_value("retire rd_wen", {31'b0, retire.rd_wen}, {31'b0, expected.rd_wen});
        check_value("retire rd_data", retire.rd_data, expected.rd_data);
        retire_ready = 1'b1;
        @(negedge clk);
        retire_ready = 1'b0;
endtask

initial
begin : main
        int count;

        clk            = 1'b0;
        arst_n         = 1'b0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        retire_ready   = 1'b0;
        m_pc           = '0;
        for (int i = 0; i < 32; i++)
                m_regs[i] = '0;
        for (int i = 0; i < MODEL_WORDS; i++)
                m_mem[i] = '0;
        build_program();

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        count = 0;
        while (m_pc != word_t'(prog_len * 4))
        begin
                run_instruction();
                count++;
                if (count > MAX_RETIRE)
                        stop_on_error("the program never reached its last instruction");
        end

        if (rv_core_i.rv_core_props_i.prop_errors == 0)
        begin
                $display("TESTS PASSED");
                $finish;
        end
        else
        begin
                stop_on_error("a handshake property failed during the run");
        end
end

endmodule
